//--- Bender.yml
package:
  name: dispatch_stage

sources:
  - src/core_cfg_pkg.sv
  - src/dispatch_types_pkg.sv
  - src/map_table.sv
  - src/reorder_buffer.sv
  - src/arch_regfile.sv
  - src/dispatcher.sv
  - src/dispatch_top.sv
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/dispatch_assert.sv
      - dv/tb_dispatch.sv

//--- dv/dispatch_assert.sv
`timescale 1ns/10ps

module dispatch_assert import core_cfg_pkg::*, dispatch_types_pkg::*; (
    input logic          clk,
    input logic          arst_n,
    input decoded_pack_t decoded,
    input fu_vec_t       rs_load,
    input logic          stall,
    input commit_t       commit
);

    // live entries counted from the dispatch strobes and the commits
    rob_cnt_t occupancy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            occupancy <= '0;
        end else begin
            occupancy <= occupancy + rob_cnt_t'(rs_load != '0) - rob_cnt_t'(commit.valid);
        end
    end

    rs_load_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(rs_load))
        else $error("rs_load has more than one station bit set");

    load_while_stalled: assert property (@(posedge clk) disable iff (!arst_n)
        !(stall && (rs_load != '0)))
        else $error("rs_load raised while stall is high");

    stall_needs_valid: assert property (@(posedge clk) disable iff (!arst_n)
        stall |-> decoded.valid)
        else $error("stall raised without a valid decoded packet");

    commit_from_empty: assert property (@(posedge clk) disable iff (!arst_n)
        (occupancy == '0) |-> !commit.valid)
        else $error("commit valid while the reorder buffer is empty");

endmodule

bind dispatch_top dispatch_assert u_dispatch_assert (
    .clk     (clk),
    .arst_n  (arst_n),
    .decoded (decoded),
    .rs_load (rs_load),
    .stall   (stall),
    .commit  (commit)
);

//--- dv/dispatch_cases.txt
# name valid fu func dest src1 src2 pc imm pc_v imm_v rs_full cdb_v cdb_tag cdb_data (all hex)
# then: rs_load stall rdy1 val1 tag1 rdy2 val2 tag2 tag_dest commit_v commit_dest commit_data
empty_alu      1 0 1 1 2 3 100 0  0 0 0 0 0 0   1 0 1 0   0 1 0  0 0 0 0 0
empty_mult     1 1 2 2 4 5 104 0  0 0 0 0 0 0   2 0 1 0   0 1 0  0 1 0 0 0
dep_wait       1 0 3 3 1 2 108 0  0 0 0 0 0 0   1 0 0 0   0 0 0  1 2 0 0 0
subst_pc_imm   1 3 4 4 1 2 200 8  1 1 0 0 0 0   8 0 1 200 0 1 8  0 3 0 0 0
btu_regs       1 2 5 0 1 5 300 40 1 1 0 0 0 0   4 0 0 0   0 1 0  0 4 0 0 0
rs_full_stall  1 1 6 5 3 0 400 0  0 0 2 0 0 0   0 1 0 0   0 0 0  0 0 0 0 0
rs_full_other  1 1 6 5 3 0 400 0  0 0 d 0 0 0   2 0 0 0   2 1 0  0 5 0 0 0
fill_a         1 0 1 6 0 0 500 0  0 0 0 0 0 0   1 0 1 0   0 1 0  0 6 0 0 0
fill_b         1 0 1 7 0 0 504 0  0 0 0 0 0 0   1 0 1 0   0 1 0  0 7 0 0 0
rob_full       1 0 1 8 0 4 508 0  0 0 0 1 1 22  0 1 0 0   0 0 0  0 0 0 0 0
rob_full_hold  1 0 1 8 0 4 508 0  0 0 0 1 0 11  0 1 0 0   0 0 0  0 0 0 0 0
commit_0       1 0 1 8 0 4 508 0  0 0 0 0 0 0   0 1 0 0   0 0 0  0 0 1 1 11
commit_1       1 0 1 8 0 4 508 0  0 0 0 1 3 44  1 0 1 0   0 0 0  3 0 1 2 22
read_after_cdb 1 0 1 9 1 4 50c 0  0 0 0 0 0 0   1 0 1 11  0 1 44 0 1 0 0 0
cdb_tag2       0 0 0 0 0 0 0   0  0 0 0 1 2 33  0 0 0 0   0 0 0  0 0 0 0 0
commit_2       0 0 0 0 0 0 0   0  0 0 0 0 0 0   0 0 0 0   0 0 0  0 0 1 3 33
commit_3       0 0 0 0 0 0 0   0  0 0 0 0 0 0   0 0 0 0   0 0 0  0 0 1 4 44
read_committed 1 0 1 0 3 4 600 0  0 0 0 0 0 0   1 0 1 33  0 1 44 0 2 0 0 0
cdb_tag4       0 0 0 0 0 0 0   0  0 0 0 1 4 55  0 0 0 0   0 0 0  0 0 0 0 0
commit_x0      0 0 0 0 0 0 0   0  0 0 0 0 0 0   0 0 0 0   0 0 0  0 0 1 0 55
read_x0        1 0 1 0 0 0 700 0  0 0 0 0 0 0   1 0 1 0   0 1 0  0 3 0 0 0
lsu_full       1 3 7 a 5 6 800 0  0 0 8 0 0 0   0 1 0 0   0 0 0  0 0 0 0 0
lsu_release    1 3 7 a 5 6 800 0  0 0 0 0 0 0   8 0 0 0   5 0 0  6 4 0 0 0

//--- dv/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk
);

    // 100 ns period
    localparam int HALF_PERIOD = 50;

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD) clk = ~clk;
        end
    end

endmodule

//--- dv/tb_dispatch.sv
`timescale 1ns/10ps

module tb_dispatch import core_cfg_pkg::*, dispatch_types_pkg::*; ();

    localparam CASE_FILE         = "dv/dispatch_cases.txt";
    localparam int RESET_CYCLES  = 4;
    localparam int TIMEOUT_SLACK = 20;
    // sample point just ahead of the next rising edge
    localparam int SAMPLE_DELAY  = 40;

    // one cycle of stimulus together with its expected response
    typedef struct packed {
        decoded_pack_t dec;
        fu_vec_t       rs_full;
        cdb_t          cdb;
        fu_vec_t       exp_load;
        logic          exp_stall;
        logic          exp_rdy1;
        xlen_t         exp_val1;
        rob_tag_t      exp_tag1;
        logic          exp_rdy2;
        xlen_t         exp_val2;
        rob_tag_t      exp_tag2;
        rob_tag_t      exp_tag_dest;
        commit_t       exp_commit;
    } cycle_case_t;

    logic          clk;
    logic          arst_n;
    decoded_pack_t decoded;
    fu_vec_t       rs_full;
    cdb_t          cdb;
    inst_rs_t      inst_rs;
    fu_vec_t       rs_load;
    logic          stall;
    commit_t       commit;

    cycle_case_t cases[$];
    string       names[$];
    int          num_checks;
    int          num_errors;
    int          num_commits;
    int          cycle_count;
    int          cycle_limit;

    tb_clock_gen u_clock_gen (
        .clk (clk)
    );

    dispatch_top u_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .decoded (decoded),
        .rs_full (rs_full),
        .cdb     (cdb),
        .inst_rs (inst_rs),
        .rs_load (rs_load),
        .stall   (stall),
        .commit  (commit)
    );

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        string       nm;
        logic [31:0] f [26];
        cycle_case_t c;

        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("cannot open case file %s", CASE_FILE);
            num_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // blank and comment lines
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line,
                "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                nm, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
                f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21], f[22],
                f[23], f[24], f[25]);
            if (n != 27) begin
                $display("malformed line in case file: %s", line);
                num_errors++;
                continue;
            end
            c                  = '0;
            c.dec.valid        = f[0][0];
            c.dec.fu           = fu_e'(f[1][1:0]);
            c.dec.alu_func     = alu_func_t'(f[2]);
            c.dec.dest         = reg_addr_t'(f[3]);
            c.dec.src1         = reg_addr_t'(f[4]);
            c.dec.src2         = reg_addr_t'(f[5]);
            c.dec.pc           = f[6];
            c.dec.imm          = f[7];
            c.dec.pc_valid     = f[8][0];
            c.dec.imm_valid    = f[9][0];
            c.rs_full          = fu_vec_t'(f[10]);
            c.cdb.valid        = f[11][0];
            c.cdb.tag          = rob_tag_t'(f[12]);
            c.cdb.data         = f[13];
            c.exp_load         = fu_vec_t'(f[14]);
            c.exp_stall        = f[15][0];
            c.exp_rdy1         = f[16][0];
            c.exp_val1         = f[17];
            c.exp_tag1         = rob_tag_t'(f[18]);
            c.exp_rdy2         = f[19][0];
            c.exp_val2         = f[20];
            c.exp_tag2         = rob_tag_t'(f[21]);
            c.exp_tag_dest     = rob_tag_t'(f[22]);
            c.exp_commit.valid = f[23][0];
            c.exp_commit.dest  = reg_addr_t'(f[24]);
            c.exp_commit.data  = f[25];
            cases.push_back(c);
            names.push_back(nm);
        end
        $fclose(fd);
    endtask

    task automatic apply_case(input cycle_case_t c);
        decoded = c.dec;
        rs_full = c.rs_full;
        cdb     = c.cdb;
    endtask

    task automatic compare_field(input string name, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
        num_checks++;
        if (actual !== expected) begin
            num_errors++;
            $display("FAILED %s %s: expected %h, actual %h", name, field, expected, actual);
        end
    endtask

    task automatic verify_outputs(input string name, input cycle_case_t c);
        xlen_t exp_imm;
        xlen_t exp_pc;

        compare_field(name, "stall", c.exp_stall, stall);
        compare_field(name, "rs_load", c.exp_load, rs_load);
        compare_field(name, "commit.valid", c.exp_commit.valid, commit.valid);
        if (c.exp_commit.valid) begin
            compare_field(name, "commit.dest", c.exp_commit.dest, commit.dest);
            compare_field(name, "commit.data", c.exp_commit.data, commit.data);
            // in-order retirement hands back the tags in allocation order
            compare_field(name, "commit.tag", rob_tag_t'(num_commits), commit.tag);
            num_commits++;
        end
        // station entry only counts while a load strobe is up
        if (c.exp_load != '0) begin
            // branches carry pc and imm in the entry, other units get zeros there
            exp_imm = (c.dec.fu == FU_BTU) ? c.dec.imm : '0;
            exp_pc  = (c.dec.fu == FU_BTU) ? c.dec.pc : '0;
            compare_field(name, "fu", c.dec.fu, inst_rs.fu);
            compare_field(name, "func", c.dec.alu_func, inst_rs.func);
            compare_field(name, "tag_dest", c.exp_tag_dest, inst_rs.tag_dest);
            compare_field(name, "ready_src1", c.exp_rdy1, inst_rs.ready_src1);
            compare_field(name, "value_src1", c.exp_val1, inst_rs.value_src1);
            if (!c.exp_rdy1) begin
                compare_field(name, "tag_src1", c.exp_tag1, inst_rs.tag_src1);
            end
            compare_field(name, "ready_src2", c.exp_rdy2, inst_rs.ready_src2);
            compare_field(name, "value_src2", c.exp_val2, inst_rs.value_src2);
            if (!c.exp_rdy2) begin
                compare_field(name, "tag_src2", c.exp_tag2, inst_rs.tag_src2);
            end
            compare_field(name, "imm", exp_imm, inst_rs.imm);
            compare_field(name, "pc", exp_pc, inst_rs.pc);
        end
    endtask

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", num_checks, num_errors);
        if (num_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    // watchdog limit is known once the case file is read
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            num_errors++;
            finish_run();
        end
    end

    initial begin
        arst_n      = 1'b0;
        decoded     = '0;
        rs_full     = '0;
        cdb         = '0;
        num_checks  = 0;
        num_errors  = 0;
        num_commits = 0;
        cycle_count = 0;
        cycle_limit = 0;
        load_cases();
        cycle_limit = cases.size() + RESET_CYCLES + TIMEOUT_SLACK;
        if (cases.size() == 0) begin
            $display("no cases were loaded, nothing was checked");
            num_errors++;
        end else begin
            repeat (RESET_CYCLES) @(posedge clk);
            @(negedge clk);
            arst_n = 1'b1;
            foreach (cases[i]) begin
                apply_case(cases[i]);
                #(SAMPLE_DELAY);
                verify_outputs(names[i], cases[i]);
                @(negedge clk);
            end
        end
        finish_run();
    end

endmodule

//--- sources.f
src/core_cfg_pkg.sv
src/dispatch_types_pkg.sv
src/map_table.sv
src/reorder_buffer.sv
src/arch_regfile.sv
src/dispatcher.sv
src/dispatch_top.sv
dv/tb_clock_gen.sv
dv/dispatch_assert.sv
dv/tb_dispatch.sv

//--- src/arch_regfile.sv
`timescale 1ns/10ps

module arch_regfile import core_cfg_pkg::*, dispatch_types_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  commit_t   commit,
    output reg_file_t registers
);

    logic wr_en;

    // writes to x0 are dropped so it reads as zero
    assign wr_en = commit.valid && (commit.dest != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            registers <= '0;
        end else if (wr_en) begin
            registers[commit.dest] <= commit.data;
        end
    end

endmodule

//--- src/core_cfg_pkg.sv
package core_cfg_pkg;

    // datapath and register file
    localparam int XLEN         = 32;
    localparam int REG_NUM      = 32;
    localparam int REG_ADDR_LEN = $clog2(REG_NUM);

    // reorder buffer geometry
    localparam int ROB_SIZE     = 8;
    localparam int ROB_TAG_LEN  = 3;

    // one reservation station per function unit
    localparam int FU_NUM       = 4;

    localparam int ALU_FUNC_LEN = 4;

    typedef logic [XLEN-1:0]         xlen_t;
    typedef logic [REG_ADDR_LEN-1:0] reg_addr_t;
    typedef logic [ROB_TAG_LEN-1:0]  rob_tag_t;
    typedef logic [ALU_FUNC_LEN-1:0] alu_func_t;

    // occupancy counter needs one bit more than the tag to tell full from empty
    typedef logic [ROB_TAG_LEN:0]    rob_cnt_t;

    // one bit per station, indexed by fu_e
    typedef logic [FU_NUM-1:0]       fu_vec_t;

    typedef xlen_t [REG_NUM-1:0]     reg_file_t;

    typedef enum logic [1:0] {
        FU_ALU  = 2'd0,
        FU_MULT = 2'd1,
        FU_BTU  = 2'd2,
        FU_LSU  = 2'd3
    } fu_e;

endpackage

//--- src/dispatch_top.sv
`timescale 1ns/10ps

module dispatch_top import core_cfg_pkg::*, dispatch_types_pkg::*; (
    input  logic          clk,
    input  logic          arst_n,
    input  decoded_pack_t decoded,
    input  fu_vec_t       rs_full,
    input  cdb_t          cdb,
    output inst_rs_t      inst_rs,
    output fu_vec_t       rs_load,
    output logic          stall,
    output commit_t       commit
);

    reg_file_t  registers;
    rob_array_t rob_entries;
    rob_tag_t   tail_tag;
    logic       rob_full;
    inst_rob_t  inst_rob;
    logic       alloc;

    dispatcher u_dispatcher (
        .clk       (clk),
        .arst_n    (arst_n),
        .decoded   (decoded),
        .registers (registers),
        .rob       (rob_entries),
        .tail_tag  (tail_tag),
        .rob_full  (rob_full),
        .rs_full   (rs_full),
        .commit    (commit),
        .inst_rs   (inst_rs),
        .inst_rob  (inst_rob),
        .alloc     (alloc),
        .rs_load   (rs_load),
        .stall     (stall)
    );

    reorder_buffer u_reorder_buffer (
        .clk      (clk),
        .arst_n   (arst_n),
        .alloc    (alloc),
        .inst_rob (inst_rob),
        .cdb      (cdb),
        .entries  (rob_entries),
        .tail_tag (tail_tag),
        .full     (rob_full),
        .commit   (commit)
    );

    arch_regfile u_arch_regfile (
        .clk       (clk),
        .arst_n    (arst_n),
        .commit    (commit),
        .registers (registers)
    );

endmodule

//--- src/dispatch_types_pkg.sv
package dispatch_types_pkg;

    import core_cfg_pkg::*;

    // packet from the decoder, held upstream while stalled
    typedef struct packed {
        logic      valid;
        fu_e       fu;
        alu_func_t alu_func;
        reg_addr_t dest;
        reg_addr_t src1;
        reg_addr_t src2;
        xlen_t     pc;
        xlen_t     imm;
        logic      pc_valid;
        logic      imm_valid;
    } decoded_pack_t;

    // rename lookup result for one source
    typedef struct packed {
        logic     mapped;
        logic     ready;
        rob_tag_t rob_tag;
    } src_map_t;

    // entry handed to a reservation station
    typedef struct packed {
        fu_e       fu;
        alu_func_t func;
        rob_tag_t  tag_dest;
        logic      ready_src1;
        xlen_t     value_src1;
        rob_tag_t  tag_src1;
        logic      ready_src2;
        xlen_t     value_src2;
        rob_tag_t  tag_src2;
        xlen_t     imm;
        xlen_t     pc;
    } inst_rs_t;

    typedef struct packed {
        logic      valid;
        logic      done;
        reg_addr_t dest;
        xlen_t     pc;
        xlen_t     npc;
        xlen_t     wb_data;
    } rob_entry_t;

    typedef rob_entry_t [ROB_SIZE-1:0] rob_array_t;

    // allocation request from the dispatcher
    typedef struct packed {
        reg_addr_t dest;
        xlen_t     pc;
        xlen_t     npc;
    } inst_rob_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        xlen_t    data;
    } cdb_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t dest;
        rob_tag_t  tag;
        xlen_t     data;
    } commit_t;

endpackage

//--- src/dispatcher.sv
`timescale 1ns/10ps

module dispatcher import core_cfg_pkg::*, dispatch_types_pkg::*; (
    input  logic          clk,
    input  logic          arst_n,

    // packet from decode
    input  decoded_pack_t decoded,

    // operand sources
    input  reg_file_t     registers,
    input  rob_array_t    rob,

    // rob status
    input  rob_tag_t      tail_tag,
    input  logic          rob_full,

    // station back-pressure
    input  fu_vec_t       rs_full,

    // retirement, used to clear stale mappings
    input  commit_t       commit,

    output inst_rs_t      inst_rs,
    output inst_rob_t     inst_rob,
    output logic          alloc,
    output fu_vec_t       rs_load,
    output logic          stall
);

    src_map_t map1;
    src_map_t map2;
    src_map_t src1_map;
    src_map_t src2_map;

    logic non_branch;

    map_table u_map_table (
        .clk        (clk),
        .arst_n     (arst_n),
        .src1       (decoded.src1),
        .src2       (decoded.src2),
        .dest       (decoded.dest),
        .assign_en  (alloc),
        .assign_tag (tail_tag),
        .commit     (commit),
        .map1       (map1),
        .map2       (map2)
    );

    // a mapped source is ready once its producer has written back
    always_comb begin
        src1_map       = map1;
        src1_map.ready = rob[map1.rob_tag].done;
        src2_map       = map2;
        src2_map.ready = rob[map2.rob_tag].done;
    end

    // back-pressure from the target station or a full rob
    assign stall = decoded.valid && (rs_full[decoded.fu] || rob_full);
    assign alloc = decoded.valid && !stall;

    assign rs_load = alloc ? (fu_vec_t'(1) << decoded.fu) : '0;

    assign inst_rob.dest = decoded.dest;
    assign inst_rob.pc   = decoded.pc;
    assign inst_rob.npc  = decoded.pc + xlen_t'(4);

    // branches keep register operands and carry pc and imm in their own fields
    assign non_branch = (decoded.fu != FU_BTU);

    // substitution, then regfile, then a finished rob entry, else wait on tag
    function automatic void resolve_operand(
        input  logic       subst,
        input  xlen_t      subst_value,
        input  reg_addr_t  addr,
        input  src_map_t   map,
        input  reg_file_t  regs,
        input  rob_array_t rob_arr,
        output logic       ready,
        output xlen_t      value
    );
        if (subst) begin
            ready = 1'b1;
            value = subst_value;
        end else if (!map.mapped) begin
            ready = 1'b1;
            value = regs[addr];
        end else if (map.ready) begin
            ready = 1'b1;
            value = rob_arr[map.rob_tag].wb_data;
        end else begin
            ready = 1'b0;
            value = '0;
        end
    endfunction

    always_comb begin
        inst_rs.fu       = decoded.fu;
        inst_rs.func     = decoded.alu_func;
        inst_rs.tag_dest = tail_tag;
        inst_rs.tag_src1 = src1_map.mapped ? src1_map.rob_tag : '0;
        inst_rs.tag_src2 = src2_map.mapped ? src2_map.rob_tag : '0;
        inst_rs.imm      = non_branch ? '0 : decoded.imm;
        inst_rs.pc       = non_branch ? '0 : decoded.pc;

        resolve_operand(non_branch && decoded.pc_valid, decoded.pc, decoded.src1,
                        src1_map, registers, rob, inst_rs.ready_src1, inst_rs.value_src1);
        resolve_operand(non_branch && decoded.imm_valid, decoded.imm, decoded.src2,
                        src2_map, registers, rob, inst_rs.ready_src2, inst_rs.value_src2);
    end

endmodule

//--- src/map_table.sv
`timescale 1ns/10ps

module map_table import core_cfg_pkg::*, dispatch_types_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,

    // lookup ports
    input  reg_addr_t src1,
    input  reg_addr_t src2,

    // rename of the destination on allocation
    input  reg_addr_t dest,
    input  logic      assign_en,
    input  rob_tag_t  assign_tag,

    input  commit_t   commit,

    output src_map_t  map1,
    output src_map_t  map2
);

    logic [REG_NUM-1:0] mapped;
    rob_tag_t           tags [REG_NUM];

    logic do_assign;
    logic do_clear;

    // x0 is never renamed
    assign do_assign = assign_en && (dest != '0);

    // only clear if no younger writer took the register over
    assign do_clear = commit.valid && mapped[commit.dest] && (tags[commit.dest] == commit.tag);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mapped <= '0;
        end else begin
            if (do_clear) begin
                mapped[commit.dest] <= 1'b0;
            end
            // assign comes last so it wins over a same-cycle clear
            if (do_assign) begin
                mapped[dest] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_assign) begin
            tags[dest] <= assign_tag;
        end
    end

    // ready is resolved by the dispatcher from the rob done bit
    assign map1.mapped  = mapped[src1];
    assign map1.ready   = 1'b0;
    assign map1.rob_tag = tags[src1];

    assign map2.mapped  = mapped[src2];
    assign map2.ready   = 1'b0;
    assign map2.rob_tag = tags[src2];

endmodule

//--- src/reorder_buffer.sv
`timescale 1ns/10ps

module reorder_buffer import core_cfg_pkg::*, dispatch_types_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,

    // allocation from dispatch
    input  logic       alloc,
    input  inst_rob_t  inst_rob,

    // completion broadcast
    input  cdb_t       cdb,

    output rob_array_t entries,
    output rob_tag_t   tail_tag,
    output logic       full,
    output commit_t    commit
);

    rob_tag_t head;
    rob_tag_t tail;
    rob_cnt_t count;

    logic retire;

    assign full     = (count == rob_cnt_t'(ROB_SIZE));
    assign tail_tag = tail;

    // head retires as soon as its result is back
    assign retire = entries[head].valid && entries[head].done;

    assign commit.valid = retire;
    assign commit.dest  = entries[head].dest;
    assign commit.tag   = head;
    assign commit.data  = entries[head].wb_data;

    // pointers wrap naturally with a power of two size
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (retire) begin
                head <= head + rob_tag_t'(1);
            end
            if (alloc) begin
                tail <= tail + rob_tag_t'(1);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else begin
            case ({alloc, retire})
                2'b10:   count <= count + rob_cnt_t'(1);
                2'b01:   count <= count - rob_cnt_t'(1);
                default: count <= count;
            endcase
        end
    end

    // entry updates from completion, retirement and allocation
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < ROB_SIZE; i++) begin
                entries[i].valid <= 1'b0;
                entries[i].done  <= 1'b0;
            end
        end else begin
            if (cdb.valid) begin
                entries[cdb.tag].done    <= 1'b1;
                entries[cdb.tag].wb_data <= cdb.data;
            end
            if (retire) begin
                entries[head].valid <= 1'b0;
                entries[head].done  <= 1'b0;
            end
            // tail never equals a live head, dispatch stalls when full
            if (alloc) begin
                entries[tail].valid <= 1'b1;
                entries[tail].done  <= 1'b0;
                entries[tail].dest  <= inst_rob.dest;
                entries[tail].pc    <= inst_rob.pc;
                entries[tail].npc   <= inst_rob.npc;
            end
        end
    end

endmodule
